//--- compile.f
logic/dcache_pkg.sv
logic/load_store_align.sv
logic/dcache_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/block_mem_model.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/load_store_align.sv
  - logic/dcache_array.sv
  - logic/dcache_ctrl.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - verification/block_mem_model.sv
      - verification/dcache_tb.sv

//--- verification/dcache_tb.sv
`default_nettype none

module dcache_tb;

    import dcache_pkg::*;

    localparam int line_width     = default_words_per_line * word_width;
    localparam int line_bytes     = default_words_per_line * word_bytes;
    localparam int offset_bits    = $clog2(line_bytes);
    localparam int tag_shift      = offset_bits + default_index_width;
    localparam int num_lines      = 1 << default_index_width;
    localparam int mem_words      = 4096;
    localparam int timeout_cycles = 200;
    localparam int n_ops          = 27;

    // The fill column marks accesses that must fetch a line
    typedef struct packed {
        logic                  we;
        funct3_t               funct3;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        logic                  fill;
    } op_t;

    logic                  clk;
    logic                  reset;
    logic                  req;
    logic                  we;
    funct3_t               funct3;
    logic [addr_width-1:0] addr;
    logic [word_width-1:0] wdata;
    logic [word_width-1:0] rdata;
    logic                  resp_valid;
    logic                  busy;
    logic                  mem_read;
    logic                  mem_write;
    logic [addr_width-1:0] mem_addr;
    logic [line_width-1:0] mem_wdata;
    logic [line_bytes-1:0] mem_be;
    logic [line_width-1:0] mem_rdata;
    logic                  mem_ready;

    op_t                   ops [n_ops];
    logic [word_width-1:0] image [mem_words];
    int                    shadow_tag [num_lines];
    logic                  shadow_valid [num_lines];
    int                    errors = 0;
    int                    tests_failed = 0;
    int                    tests_run = 1;
    int                    read_count = 0;
    int                    write_count = 0;
    logic                  timed_out = 1'b0;
    logic [line_bytes-1:0] last_be;
    logic [line_width-1:0] last_wdata;
    logic [addr_width-1:0] last_read_addr;
    logic [addr_width-1:0] last_write_addr;

    dcache_top dcache_top_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .we         (we),
        .funct3     (funct3),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .resp_valid (resp_valid),
        .busy       (busy),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_be     (mem_be),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    block_mem_model #(
        .mem_words (mem_words)
    ) block_mem_model_i (
        .clk       (clk),
        .reset     (reset),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory transfers as seen on the bus
    always @(negedge clk) begin
        if (!reset && mem_ready && mem_read) begin
            read_count++;
            last_read_addr = mem_addr;
        end
        if (!reset && mem_ready && mem_write) begin
            write_count++;
            last_be = mem_be;
            last_wdata = mem_wdata;
            last_write_addr = mem_addr;
        end
    end

    function automatic logic [31:0] load_expect(funct3_t f3, logic [31:0] word, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8 * off +: 8];
        h = word[16 * off[1] +: 16];
        case (f3)
            f3_byte:   return {{24{b[7]}}, b};
            f3_half:   return {{16{h[15]}}, h};
            f3_byte_u: return {24'h0, b};
            f3_half_u: return {16'h0, h};
            default:   return word;
        endcase
    endfunction

    function automatic logic [3:0] mask_for(funct3_t f3, logic [1:0] off);
        case (f3)
            f3_byte: return 4'b0001 << off;
            f3_half: return 4'b0011 << {off[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] byte_bits(logic [3:0] mask);
        logic [31:0] bits;
        for (int b = 0; b < 4; b++) begin
            bits[8 * b +: 8] = {8{mask[b]}};
        end
        return bits;
    endfunction

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic run_op(input int n, output logic stalled);
        op_t                   op;
        int                    cycles;
        int                    reads0;
        int                    writes0;
        int                    errors0;
        int                    idx;
        int                    word_idx;
        logic [2:0]            lane;
        logic                  predict_fill;
        logic [31:0]           bits;
        logic [31:0]           expect_data;
        logic [line_bytes-1:0] be_expect;
        logic [addr_width-1:0] line_addr;
        stalled = 1'b0;
        op = ops[n];
        errors0 = errors;
        idx = (op.addr >> offset_bits) % num_lines;
        word_idx = op.addr >> 2;
        lane = op.addr[4:2];
        line_addr = (op.addr >> offset_bits) << offset_bits;
        predict_fill = !op.we && !(shadow_valid[idx] && shadow_tag[idx] == (op.addr >> tag_shift));
        reads0 = read_count;
        writes0 = write_count;
        @(negedge clk);
        req = 1'b1;
        we = op.we;
        funct3 = op.funct3;
        addr = op.addr;
        wdata = op.wdata;
        @(negedge clk);
        req = 1'b0;
        cycles = 1;
        while (!resp_valid && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid) begin
            plain_error($sformatf("Operation %0d got no response within %0d cycles",
                                  n, timeout_cycles));
            tests_failed++;
            stalled = 1'b1;
            return;
        end
        assert (predict_fill == op.fill)
            else plain_error("Shadow tags and operation table disagree on a fill");
        assert (!busy) else value_error("busy", busy, 0);
        assert (read_count - reads0 == int'(predict_fill))
            else value_error("mem_read transfers", read_count - reads0, predict_fill);
        if (predict_fill) begin
            assert (last_read_addr == line_addr)
                else value_error("mem_addr", last_read_addr, line_addr);
        end
        if (op.we) begin
            bits = byte_bits(mask_for(op.funct3, op.addr[1:0]));
            case (op.funct3)
                f3_byte: expect_data = {4{op.wdata[7:0]}};
                f3_half: expect_data = {2{op.wdata[15:0]}};
                default: expect_data = op.wdata;
            endcase
            image[word_idx] = (image[word_idx] & ~bits) | (expect_data & bits);
            be_expect = '0;
            be_expect[lane * 4 +: 4] = mask_for(op.funct3, op.addr[1:0]);
            assert (write_count - writes0 == 1)
                else value_error("mem_write transfers", write_count - writes0, 1);
            assert (last_write_addr == line_addr)
                else value_error("mem_addr", last_write_addr, line_addr);
            assert (last_be == be_expect) else value_error("mem_be", last_be, be_expect);
            assert ((last_wdata[lane * 32 +: 32] & bits) == (image[word_idx] & bits))
                else value_error("mem_wdata", last_wdata[lane * 32 +: 32], image[word_idx]);
            assert (rdata == '0) else value_error("rdata", rdata, 0);
        end else begin
            expect_data = load_expect(op.funct3, image[word_idx], op.addr[1:0]);
            assert (rdata == expect_data) else value_error("rdata", rdata, expect_data);
            if (!predict_fill) begin
                assert (cycles == 1) else plain_error("Load hit answered later than one cycle");
            end
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx] = op.addr >> tag_shift;
        end
        if (errors != errors0) begin
            tests_failed++;
        end
        $display("op %2d %s %s addr 0x%08h: %s", n, op.we ? "store" : "load ",
                 op.funct3.name(), op.addr, errors == errors0 ? "ok" : "FAILED");
    endtask

    initial begin
        reset = 1'b1;
        req = 1'b0;
        we = 1'b0;
        funct3 = f3_word;
        addr = '0;
        wdata = '0;
        for (int i = 0; i < mem_words; i++) begin
            image[i] = i ^ 32'h5A5A0000;
        end
        for (int i = 0; i < num_lines; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i] = 0;
        end
        ops = '{
            '{1'b0, f3_word,   32'h0000_0200, 32'h0000_0000, 1'b1},
            '{1'b0, f3_byte,   32'h0000_0200, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte_u, 32'h0000_0201, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte,   32'h0000_0202, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte_u, 32'h0000_0203, 32'h0000_0000, 1'b0},
            '{1'b0, f3_half_u, 32'h0000_0200, 32'h0000_0000, 1'b0},
            '{1'b0, f3_half,   32'h0000_0202, 32'h0000_0000, 1'b0},
            '{1'b1, f3_word,   32'h0000_0204, 32'h81F2_93E4, 1'b0},
            '{1'b0, f3_byte_u, 32'h0000_0204, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte,   32'h0000_0205, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte_u, 32'h0000_0206, 32'h0000_0000, 1'b0},
            '{1'b0, f3_byte,   32'h0000_0207, 32'h0000_0000, 1'b0},
            '{1'b0, f3_half,   32'h0000_0204, 32'h0000_0000, 1'b0},
            '{1'b0, f3_half_u, 32'h0000_0206, 32'h0000_0000, 1'b0},
            '{1'b1, f3_byte,   32'h0000_0209, 32'h0000_00A5, 1'b0},
            '{1'b1, f3_half,   32'h0000_020E, 32'h0000_C3D2, 1'b0},
            '{1'b0, f3_word,   32'h0000_0208, 32'h0000_0000, 1'b0},
            '{1'b0, f3_half,   32'h0000_020E, 32'h0000_0000, 1'b0},
            '{1'b1, f3_word,   32'h0000_0640, 32'h1357_9BDF, 1'b0},
            '{1'b1, f3_half,   32'h0000_0646, 32'h0000_9E5D, 1'b0},
            '{1'b0, f3_word,   32'h0000_0640, 32'h0000_0000, 1'b1},
            '{1'b0, f3_half,   32'h0000_0646, 32'h0000_0000, 1'b0},
            '{1'b0, f3_word,   32'h0000_0300, 32'h0000_0000, 1'b1},
            '{1'b0, f3_word,   32'h0000_0B00, 32'h0000_0000, 1'b1},
            '{1'b0, f3_word,   32'h0000_0300, 32'h0000_0000, 1'b1},
            '{1'b0, f3_word,   32'h0000_0B04, 32'h0000_0000, 1'b1},
            '{1'b0, f3_word,   32'h0000_0B08, 32'h0000_0000, 1'b0}
        };
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!busy && !mem_read && !mem_write && !resp_valid) else begin
            plain_error("Control outputs are not low after reset");
            tests_failed++;
        end
        $display("reset state: %s",
                 (busy || mem_read || mem_write || resp_valid) ? "FAILED" : "ok");
        for (int i = 0; i < n_ops && !timed_out; i++) begin
            run_op(i, timed_out);
            tests_run++;
        end
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/block_mem_model.sv
`default_nettype none

module block_mem_model #(
    parameter int  words_per_line = dcache_pkg::default_words_per_line,
    parameter int  mem_words      = 4096,
    localparam int line_width     = words_per_line * dcache_pkg::word_width,
    localparam int line_bytes     = words_per_line * dcache_pkg::word_bytes
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic [dcache_pkg::addr_width-1:0] mem_addr,
    input  logic [line_width-1:0]             mem_wdata,
    input  logic [line_bytes-1:0]             mem_be,
    output logic [line_width-1:0]             mem_rdata,
    output logic                              mem_ready
);

    import dcache_pkg::*;

    logic [word_width-1:0] words [mem_words];
    logic [15:0]           lfsr = 16'd87;
    logic [1:0]            wait_left;
    logic                  pending;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            words[i] = i ^ 32'h5A5A0000;
        end
    end

    always @(posedge clk) begin
        logic [15:0] s1;
        logic [15:0] s2;
        int          base;
        base = int'(mem_addr >> 2);
        if (reset) begin
            mem_ready <= 1'b0;
            pending <= 1'b0;
        end else if (mem_ready) begin
            // Transfer completes on this edge
            mem_ready <= 1'b0;
            pending <= 1'b0;
            if (mem_write) begin
                for (int b = 0; b < line_bytes; b++) begin
                    if (mem_be[b]) begin
                        words[base + b / word_bytes][8 * (b % word_bytes) +: 8] =
                            mem_wdata[8 * b +: 8];
                    end
                end
            end
        end else if (pending) begin
            if (wait_left == 2'd0) begin
                mem_ready <= 1'b1;
                for (int w = 0; w < words_per_line; w++) begin
                    mem_rdata[w * word_width +: word_width] <= words[base + w];
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (mem_read || mem_write) begin
            // Two LFSR bits give 1 to 4 cycles of latency
            s1 = lfsr_step(lfsr);
            s2 = lfsr_step(s1);
            lfsr <= s2;
            wait_left <= {s2[0], s1[0]};
            pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`default_nettype none

module dcache_top #(
    parameter int  index_width       = dcache_pkg::default_index_width,
    parameter int  words_per_line    = dcache_pkg::default_words_per_line,
    localparam int word_offset_width = $clog2(words_per_line),
    localparam int tag_width         = dcache_pkg::addr_width - index_width
                                       - word_offset_width - dcache_pkg::byte_offset_width,
    localparam int line_width        = words_per_line * dcache_pkg::word_width,
    localparam int line_bytes        = words_per_line * dcache_pkg::word_bytes
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req,
    input  logic                               we,
    input  dcache_pkg::funct3_t                funct3,
    input  logic [dcache_pkg::addr_width-1:0]  addr,
    input  logic [dcache_pkg::word_width-1:0]  wdata,
    output logic [dcache_pkg::word_width-1:0]  rdata,
    output logic                               resp_valid,
    output logic                               busy,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [dcache_pkg::addr_width-1:0]  mem_addr,
    output logic [line_width-1:0]              mem_wdata,
    output logic [line_bytes-1:0]              mem_be,
    input  logic [line_width-1:0]              mem_rdata,
    input  logic                               mem_ready
);

    import dcache_pkg::*;

    logic [index_width-1:0]       lookup_index;
    logic [tag_width-1:0]         lookup_tag;
    logic [word_offset_width-1:0] word_offset;
    logic [byte_offset_width-1:0] byte_offset;
    funct3_t                      funct3_q;
    logic [word_width-1:0]        store_data_q;
    logic                         hit;
    logic [word_width-1:0]        line_word;
    logic [word_width-1:0]        load_data;
    logic [word_width-1:0]        store_word;
    logic [word_bytes-1:0]        store_mask;
    logic                         fill;
    logic [line_width-1:0]        fill_line;
    logic                         word_we;

    dcache_ctrl #(
        .index_width    (index_width),
        .words_per_line (words_per_line)
    ) dcache_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .we           (we),
        .funct3       (funct3),
        .addr         (addr),
        .wdata        (wdata),
        .hit          (hit),
        .load_data    (load_data),
        .store_word   (store_word),
        .store_mask   (store_mask),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_offset  (word_offset),
        .byte_offset  (byte_offset),
        .funct3_q     (funct3_q),
        .store_data_q (store_data_q),
        .fill         (fill),
        .fill_line    (fill_line),
        .word_we      (word_we),
        .resp_valid   (resp_valid),
        .rdata        (rdata),
        .busy         (busy),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_be       (mem_be)
    );

    dcache_array #(
        .index_width    (index_width),
        .words_per_line (words_per_line)
    ) dcache_array_i (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_offset  (word_offset),
        .fill         (fill),
        .fill_line    (fill_line),
        .word_we      (word_we),
        .store_word   (store_word),
        .store_mask   (store_mask),
        .hit          (hit),
        .line_word    (line_word)
    );

    load_store_align load_store_align_i (
        .funct3      (funct3_q),
        .byte_offset (byte_offset),
        .line_word   (line_word),
        .store_data  (store_data_q),
        .load_data   (load_data),
        .store_word  (store_word),
        .store_mask  (store_mask)
    );

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl #(
    parameter int  index_width       = dcache_pkg::default_index_width,
    parameter int  words_per_line    = dcache_pkg::default_words_per_line,
    localparam int word_offset_width = $clog2(words_per_line),
    localparam int tag_width         = dcache_pkg::addr_width - index_width
                                       - word_offset_width - dcache_pkg::byte_offset_width,
    localparam int line_width        = words_per_line * dcache_pkg::word_width,
    localparam int line_bytes        = words_per_line * dcache_pkg::word_bytes
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      req,
    input  logic                                      we,
    input  dcache_pkg::funct3_t                       funct3,
    input  logic [dcache_pkg::addr_width-1:0]         addr,
    input  logic [dcache_pkg::word_width-1:0]         wdata,
    input  logic                                      hit,
    input  logic [dcache_pkg::word_width-1:0]         load_data,
    input  logic [dcache_pkg::word_width-1:0]         store_word,
    input  logic [dcache_pkg::word_bytes-1:0]         store_mask,
    input  logic [line_width-1:0]                     mem_rdata,
    input  logic                                      mem_ready,
    output logic [index_width-1:0]                    lookup_index,
    output logic [tag_width-1:0]                      lookup_tag,
    output logic [word_offset_width-1:0]              word_offset,
    output logic [dcache_pkg::byte_offset_width-1:0]  byte_offset,
    output dcache_pkg::funct3_t                       funct3_q,
    output logic [dcache_pkg::word_width-1:0]         store_data_q,
    output logic                                      fill,
    output logic [line_width-1:0]                     fill_line,
    output logic                                      word_we,
    output logic                                      resp_valid,
    output logic [dcache_pkg::word_width-1:0]         rdata,
    output logic                                      busy,
    output logic                                      mem_read,
    output logic                                      mem_write,
    output logic [dcache_pkg::addr_width-1:0]         mem_addr,
    output logic [line_width-1:0]                     mem_wdata,
    output logic [line_bytes-1:0]                     mem_be
);

    import dcache_pkg::*;

    localparam int line_offset_width = word_offset_width + byte_offset_width;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_fetch,
        st_write_through
    } state_t;

    state_t                state_q;
    logic [addr_width-1:0] addr_q;
    logic                  we_q;
    logic                  mem_read_q;
    logic                  mem_write_q;
    logic                  resp_store_q;
    logic                  in_lookup;
    logic                  load_hit;

    if (line_bytes > line_bytes_max) begin : g_line_too_wide
        $error("dcache_ctrl: line of %0d bytes exceeds %0d", line_bytes, line_bytes_max);
    end

    // Address split of the latched request
    assign lookup_index = addr_q[line_offset_width +: index_width];
    assign lookup_tag   = addr_q[addr_width-1 -: tag_width];
    assign word_offset  = addr_q[byte_offset_width +: word_offset_width];
    assign byte_offset  = addr_q[byte_offset_width-1:0];
    assign mem_addr     = {addr_q[addr_width-1:line_offset_width], {line_offset_width{1'b0}}};

    assign in_lookup  = (state_q == st_lookup);
    assign load_hit   = in_lookup && !we_q && hit;
    assign word_we    = in_lookup && we_q && hit;
    assign resp_valid = load_hit || resp_store_q;
    assign rdata      = load_hit ? load_data : '0;
    assign busy       = (state_q != st_idle) && !load_hit;
    assign mem_read   = mem_read_q || (in_lookup && !we_q && !hit);
    assign mem_write  = mem_write_q || (in_lookup && we_q);

    // Store word sits in its own lane with the other lanes disabled
    always_comb begin
        mem_wdata = '0;
        mem_be = '0;
        if (mem_write) begin
            mem_wdata[word_offset * word_width +: word_width] = store_word;
            mem_be[word_offset * word_bytes +: word_bytes] = store_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && req) begin
            addr_q <= addr;
            we_q <= we;
            funct3_q <= funct3;
            store_data_q <= wdata;
        end
        if (mem_read && mem_ready) begin
            fill_line <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
            mem_read_q <= 1'b0;
            mem_write_q <= 1'b0;
            resp_store_q <= 1'b0;
            fill <= 1'b0;
        end else begin
            fill <= 1'b0;
            resp_store_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (req) begin
                        state_q <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (we_q) begin
                        // Write-through on hit and miss alike without allocating
                        mem_write_q <= !mem_ready;
                        resp_store_q <= mem_ready;
                        state_q <= mem_ready ? st_idle : st_write_through;
                    end else if (!hit) begin
                        mem_read_q <= !mem_ready;
                        fill <= mem_ready;
                        state_q <= st_fetch;
                    end else begin
                        state_q <= st_idle;
                    end
                end
                st_fetch: begin
                    if (fill) begin
                        // Line now resident so a second lookup answers
                        state_q <= st_lookup;
                    end else if (mem_ready) begin
                        mem_read_q <= 1'b0;
                        fill <= 1'b1;
                    end
                end
                st_write_through: begin
                    if (mem_ready) begin
                        mem_write_q <= 1'b0;
                        resp_store_q <= 1'b1;
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // A new request waits until the previous response has been given
    a_req_when_free: assert property (
        @(posedge clk) disable iff (reset)
        req |-> !busy && !resp_valid
    );

    a_ready_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        mem_ready |-> mem_read || mem_write
    );

    a_resp_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid
    );

endmodule

`default_nettype wire

//--- logic/dcache_array.sv
`default_nettype none

module dcache_array #(
    parameter int  index_width       = dcache_pkg::default_index_width,
    parameter int  words_per_line    = dcache_pkg::default_words_per_line,
    localparam int word_offset_width = $clog2(words_per_line),
    localparam int tag_width         = dcache_pkg::addr_width - index_width
                                       - word_offset_width - dcache_pkg::byte_offset_width,
    localparam int line_width        = words_per_line * dcache_pkg::word_width
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [index_width-1:0]                lookup_index,
    input  logic [tag_width-1:0]                  lookup_tag,
    input  logic [word_offset_width-1:0]          word_offset,
    input  logic                                  fill,
    input  logic [line_width-1:0]                 fill_line,
    input  logic                                  word_we,
    input  logic [dcache_pkg::word_width-1:0]     store_word,
    input  logic [dcache_pkg::word_bytes-1:0]     store_mask,
    output logic                                  hit,
    output logic [dcache_pkg::word_width-1:0]     line_word
);

    import dcache_pkg::*;

    localparam int num_lines = 1 << index_width;

    logic [tag_width-1:0]  tag_table  [num_lines];
    logic [word_width-1:0] data_table [num_lines][words_per_line];
    logic [num_lines-1:0]  valid_table;

    assign hit = valid_table[lookup_index] && (tag_table[lookup_index] == lookup_tag);
    assign line_word = data_table[lookup_index][word_offset];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
        end else if (fill) begin
            valid_table[lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_table[lookup_index] <= lookup_tag;
            for (int w = 0; w < words_per_line; w++) begin
                data_table[lookup_index][w] <= fill_line[w * word_width +: word_width];
            end
        end else if (word_we) begin
            // Merge the stored bytes into the resident word
            for (int b = 0; b < word_bytes; b++) begin
                if (store_mask[b]) begin
                    data_table[lookup_index][word_offset][b * 8 +: 8] <= store_word[b * 8 +: 8];
                end
            end
        end
    end

    // A fill and a store hit never share a cycle in the controller sequence
    a_fill_or_word: assert property (
        @(posedge clk) disable iff (reset)
        !(fill && word_we)
    );

endmodule

`default_nettype wire

//--- logic/load_store_align.sv
`default_nettype none

module load_store_align (
    input  dcache_pkg::funct3_t                              funct3,
    input  logic [dcache_pkg::byte_offset_width-1:0]         byte_offset,
    input  logic [dcache_pkg::word_width-1:0]                line_word,
    input  logic [dcache_pkg::word_width-1:0]                store_data,
    output logic [dcache_pkg::word_width-1:0]                load_data,
    output logic [dcache_pkg::word_width-1:0]                store_word,
    output logic [dcache_pkg::word_bytes-1:0]                store_mask
);

    import dcache_pkg::*;

    logic [7:0]                   byte_lane;
    logic [15:0]                  half_lane;
    logic [byte_offset_width-1:0] half_shift;

    // Halfwords are taken on a 2-byte boundary
    assign byte_lane = line_word[8 * byte_offset +: 8];
    assign half_lane = line_word[16 * byte_offset[byte_offset_width-1:1] +: 16];
    assign half_shift = {byte_offset[byte_offset_width-1:1], 1'b0};

    always_comb begin
        case (funct3)
            f3_byte: begin
                load_data = {{(word_width - 8){byte_lane[7]}}, byte_lane};
            end
            f3_half: begin
                load_data = {{(word_width - 16){half_lane[15]}}, half_lane};
            end
            f3_word: begin
                load_data = line_word;
            end
            f3_byte_u: begin
                load_data = {{(word_width - 8){1'b0}}, byte_lane};
            end
            f3_half_u: begin
                load_data = {{(word_width - 16){1'b0}}, half_lane};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    // Store data is copied to every lane and the mask picks the written one
    always_comb begin
        case (funct3)
            f3_byte: begin
                store_word = {word_bytes{store_data[7:0]}};
                store_mask = {{(word_bytes - 1){1'b0}}, 1'b1} << byte_offset;
            end
            f3_half: begin
                store_word = {(word_bytes / 2){store_data[15:0]}};
                store_mask = {{(word_bytes - 2){1'b0}}, 2'b11} << half_shift;
            end
            f3_word: begin
                store_word = store_data;
                store_mask = '1;
            end
            default: begin
                // no unsigned store forms
                store_word = '0;
                store_mask = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // CPU side widths
    localparam int addr_width = 32;
    localparam int word_width = 32;

    // Bytes in one data word and the address bits that pick one of them
    localparam int word_bytes = word_width / 8;
    localparam int byte_offset_width = $clog2(word_bytes);

    // Largest line the memory side is sized for
    localparam int line_bytes_max = 64;

    // Default geometry of 64 lines with 8 words each
    localparam int default_index_width = 6;
    localparam int default_words_per_line = 8;

    // Load/store width codes as carried in funct3
    typedef enum logic [2:0] {
        f3_byte   = 3'b000,
        f3_half   = 3'b001,
        f3_word   = 3'b010,
        f3_byte_u = 3'b100,
        f3_half_u = 3'b101
    } funct3_t;

endpackage

`default_nettype wire
